// File: flist.f
rv_pkg.sv
rv_decode.sv
rv_pipe_reg.sv
rv_execute.sv
rv_result.sv
rv_core_top.sv
rv_core_checker.sv
tb_rv_core.sv

// File: rv_core_checker.sv
module rv_core_checker (
  input logic                          clk,
  input logic                          arst_n_i,
  input logic                          instr_valid_i,
  input logic                          instr_ready_o,
  input logic [rv_pkg::xlen-1:0]       instr_i,
  input logic [rv_pkg::xlen-1:0]       instr_pc_i,
  input logic                          result_valid_o,
  input logic                          result_ready_i,
  input logic [rv_pkg::reg_addr_w-1:0] result_rd_o,
  input logic [rv_pkg::xlen-1:0]       result_data_o,
  input logic                          result_illegal_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int err_count = 0;

  a_idle_in_reset: assert property (@(posedge clk) !arst_n_i |-> !result_valid_o)
    else begin
      $error("result_valid_o high during reset");
      err_count++;
    end

  // Stalled result holds its record
  a_result_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
      result_valid_o && !result_ready_i |=>
      result_valid_o && $stable({result_rd_o, result_data_o, result_illegal_o}))
    else begin
      $error("result record changed while stalled");
      err_count++;
    end

  // Stalled instruction from the environment holds too
  a_instr_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
      instr_valid_i && !instr_ready_o |=> instr_valid_i && $stable({instr_i, instr_pc_i}))
    else begin
      $error("instruction changed while stalled");
      err_count++;
    end

endmodule

bind rv_core_top rv_core_checker u_checker (.*);

// File: rv_core_top.sv
module rv_core_top (
  input  logic                          clk,
  input  logic                          arst_n_i,
  input  logic                          instr_valid_i,
  output logic                          instr_ready_o,
  input  logic [rv_pkg::xlen-1:0]       instr_i,
  input  logic [rv_pkg::xlen-1:0]       instr_pc_i,
  output logic                          result_valid_o,
  input  logic                          result_ready_i,
  output logic [rv_pkg::reg_addr_w-1:0] result_rd_o,
  output logic [rv_pkg::xlen-1:0]       result_data_o,
  output logic                          result_illegal_o
);

  import rv_pkg::*;

  dec_t                  dec_d;
  dec_t                  dec_q;
  logic                  dec_valid;
  logic                  res_ready;
  res_t                  res_d;
  res_t                  res_q;
  logic [reg_addr_w-1:0] rs1_addr;
  logic [reg_addr_w-1:0] rs2_addr;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;

  rv_decode u_decode (
    .instr_i (instr_i),
    .pc_i    (instr_pc_i),
    .dec_o   (dec_d)
  );

  rv_pipe_reg #(.payload_t(dec_t)) u_dec_reg (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .valid_i  (instr_valid_i),
    .ready_o  (instr_ready_o),
    .data_i   (dec_d),
    .valid_o  (dec_valid),
    .ready_i  (res_ready),
    .data_o   (dec_q)
  );

  rv_execute u_execute (
    .dec_i      (dec_q),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .res_o      (res_d)
  );

  rv_pipe_reg #(.payload_t(res_t)) u_res_reg (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .valid_i  (dec_valid),
    .ready_o  (res_ready),
    .data_i   (res_d),
    .valid_o  (result_valid_o),
    .ready_i  (result_ready_i),
    .data_o   (res_q)
  );

  // Writes back on the result handshake, bypasses the held record
  rv_result u_result (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .rs1_addr_i  (rs1_addr),
    .rs2_addr_i  (rs2_addr),
    .rs1_data_o  (rs1_data),
    .rs2_data_o  (rs2_data),
    .res_valid_i (result_valid_o),
    .res_ready_i (result_ready_i),
    .res_i       (res_q)
  );

  assign result_rd_o      = res_q.rd;
  assign result_data_o    = res_q.data;
  assign result_illegal_o = res_q.illegal;

endmodule

// File: rv_decode.sv
module rv_decode (
  input  logic [rv_pkg::xlen-1:0] instr_i,
  input  logic [rv_pkg::xlen-1:0] pc_i,
  output rv_pkg::dec_t            dec_o
);

  import rv_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i_type;
  logic [xlen-1:0] imm_u_type;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  // Normal-form op for a funct3, shared by reg and imm forms
  function automatic alu_op_e base_op(input logic [2:0] f3);
    case (f3)
      f3_sll:     return alu_sll;
      f3_slt:     return alu_slt;
      f3_sltu:    return alu_sltu;
      f3_xor:     return alu_xor;
      f3_srl_sra: return alu_srl;
      f3_or:      return alu_or;
      f3_and:     return alu_and;
      default:    return alu_add;
    endcase
  endfunction

  always_comb begin
    dec_o.pc       = pc_i;
    dec_o.rs1      = instr_i[19:15];
    dec_o.rs2      = instr_i[24:20];
    dec_o.rd       = instr_i[11:7];
    dec_o.imm      = imm_i_type;
    dec_o.alu_op   = base_op(funct3);
    dec_o.op_a_sel = op_a_rs1;
    dec_o.use_imm  = 1'b0;
    dec_o.illegal  = 1'b0;
    case (opcode)
      opc_op: begin
        if (funct7 == f7_alt && funct3 == f3_add_sub) begin
          dec_o.alu_op = alu_sub;
        end else if (funct7 == f7_alt && funct3 == f3_srl_sra) begin
          dec_o.alu_op = alu_sra;
        end else if (funct7 != f7_normal) begin
          dec_o.illegal = 1'b1;
        end
      end
      opc_op_imm: begin
        dec_o.use_imm = 1'b1;
        // Shift immediates carry a funct7 in imm[11:5]
        if (funct3 == f3_srl_sra && funct7 == f7_alt) begin
          dec_o.alu_op = alu_sra;
        end else if ((funct3 == f3_sll || funct3 == f3_srl_sra) && funct7 != f7_normal) begin
          dec_o.illegal = 1'b1;
        end
      end
      opc_lui: begin
        dec_o.imm      = imm_u_type;
        dec_o.use_imm  = 1'b1;
        dec_o.op_a_sel = op_a_zero;
        dec_o.alu_op   = alu_pass_b;
      end
      opc_auipc: begin
        dec_o.imm      = imm_u_type;
        dec_o.use_imm  = 1'b1;
        dec_o.op_a_sel = op_a_pc;
        dec_o.alu_op   = alu_add;
      end
      default: dec_o.illegal = 1'b1;
    endcase
    dec_o.wr_en = !dec_o.illegal;
  end

endmodule

// File: rv_execute.sv
module rv_execute (
  input  rv_pkg::dec_t                  dec_i,
  output logic [rv_pkg::reg_addr_w-1:0] rs1_addr_o,
  output logic [rv_pkg::reg_addr_w-1:0] rs2_addr_o,
  input  logic [rv_pkg::xlen-1:0]       rs1_data_i,
  input  logic [rv_pkg::xlen-1:0]       rs2_data_i,
  output rv_pkg::res_t                  res_o
);

  import rv_pkg::*;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [4:0]      shamt;
  logic [xlen-1:0] result;

  assign rs1_addr_o = dec_i.rs1;
  assign rs2_addr_o = dec_i.rs2;

  always_comb begin
    case (dec_i.op_a_sel)
      op_a_pc:   op_a = dec_i.pc;
      op_a_zero: op_a = '0;
      default:   op_a = rs1_data_i;
    endcase
  end

  assign op_b  = dec_i.use_imm ? dec_i.imm : rs2_data_i;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec_i.alu_op)
      alu_sub:    result = op_a - op_b;
      alu_xor:    result = op_a ^ op_b;
      alu_or:     result = op_a | op_b;
      alu_and:    result = op_a & op_b;
      alu_sll:    result = op_a << shamt;
      alu_srl:    result = op_a >> shamt;
      alu_sra:    result = $signed(op_a) >>> shamt;
      alu_slt:    result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu:   result = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_pass_b: result = op_b;
      default:    result = op_a + op_b;
    endcase
  end

  always_comb begin
    res_o.rd      = dec_i.rd;
    res_o.data    = result;
    res_o.wr_en   = dec_i.wr_en;
    res_o.illegal = dec_i.illegal;
  end

endmodule

// File: rv_pipe_reg.sv
module rv_pipe_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     arst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Accept when empty or when the held item leaves this cycle
  assign ready_o = !valid_q || ready_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// File: rv_pkg.sv
package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int reg_count  = 32;

  // Major opcodes handled by the core
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // Alternate form selects sub and sra
  localparam logic [6:0] f7_normal = 7'b0000000;
  localparam logic [6:0] f7_alt    = 7'b0100000;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_xor,
    alu_or,
    alu_and,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    op_a_rs1,
    op_a_pc,
    op_a_zero
  } op_a_sel_e;

  typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm;
    alu_op_e               alu_op;
    op_a_sel_e             op_a_sel;
    logic                  use_imm;
    logic                  wr_en;
    logic                  illegal;
  } dec_t;

  typedef struct packed {
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
    logic                  wr_en;
    logic                  illegal;
  } res_t;

endpackage

// File: rv_result.sv
module rv_result (
  input  logic                          clk,
  input  logic                          arst_n_i,
  input  logic [rv_pkg::reg_addr_w-1:0] rs1_addr_i,
  input  logic [rv_pkg::reg_addr_w-1:0] rs2_addr_i,
  output logic [rv_pkg::xlen-1:0]       rs1_data_o,
  output logic [rv_pkg::xlen-1:0]       rs2_data_o,
  input  logic                          res_valid_i,
  input  logic                          res_ready_i,
  input  rv_pkg::res_t                  res_i
);

  import rv_pkg::*;

  logic [xlen-1:0] regs [1:reg_count-1];
  logic            pend_wr;

  // Pending record that will be written on its handshake
  assign pend_wr = res_valid_i && res_i.wr_en && (res_i.rd != '0);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (pend_wr && res_ready_i) begin
      regs[res_i.rd] <= res_i.data;
    end
  end

  function automatic logic [xlen-1:0] read_port(input logic [reg_addr_w-1:0] addr);
    if (addr == '0) begin
      return '0;
    end else if (pend_wr && res_i.rd == addr) begin
      return res_i.data;
    end
    return regs[addr];
  endfunction

  always_comb begin
    rs1_data_o = read_port(rs1_addr_i);
  end

  always_comb begin
    rs2_data_o = read_port(rs2_addr_i);
  end

endmodule

// File: tb_rv_core.sv
module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ps;

  import rv_pkg::*;

  localparam int num_instr  = 2000;
  localparam int clk_period = 8;

  logic                  clk;
  logic                  arst_n_i;
  logic                  instr_valid_i;
  logic                  instr_ready_o;
  logic [xlen-1:0]       instr_i;
  logic [xlen-1:0]       instr_pc_i;
  logic                  result_valid_o;
  logic                  result_ready_i;
  logic [reg_addr_w-1:0] result_rd_o;
  logic [xlen-1:0]       result_data_o;
  logic                  result_illegal_o;

  integer seed     = 93667;
  int     sent     = 0;
  int     received = 0;

  logic [xlen-1:0] model_regs [0:reg_count-1];
  // Expected record as {illegal, rd, data}
  logic [xlen+reg_addr_w:0] exp_q [$];

  rv_core_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped on first error");
  endtask

  function automatic logic [xlen-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                              input logic [xlen-1:0] a,
                                              input logic [xlen-1:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101: begin
        // Kept apart so the arithmetic shift stays signed
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // Small register indices keep dependent instructions close together
  function automatic logic [xlen-1:0] gen_instr();
    logic [2:0]  kind;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    logic [19:0] upper;
    kind  = $random(seed);
    f3    = $random(seed);
    f7    = ($random(seed) & 1) ? 7'h20 : 7'h00;
    rd    = $random(seed) & 3;
    rs1   = $random(seed) & 3;
    rs2   = $random(seed) & 3;
    imm   = $random(seed);
    upper = $random(seed);
    case (kind)
      3'd0, 3'd1: begin
        if (f3 != 3'b000 && f3 != 3'b101) f7 = 7'h00;
        return {f7, rs2, rs1, f3, rd, opc_op};
      end
      3'd2, 3'd3: begin
        if (f3 == 3'b001) imm[11:5] = 7'h00;
        if (f3 == 3'b101) imm[11:5] = f7;
        return {imm, rs1, f3, rd, opc_op_imm};
      end
      3'd4:    return {upper, rd, opc_lui};
      3'd5:    return {upper, rd, opc_auipc};
      3'd6:    return $random(seed);
      default: return {imm[11:5], rs2, rs1, f3, rd, opc_op};
    endcase
  endfunction

  task automatic accept_instr(input logic [xlen-1:0] ins, input logic [xlen-1:0] pc);
    logic [6:0]      opc;
    logic [2:0]      f3;
    logic [6:0]      f7;
    logic [4:0]      rd;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] val;
    logic            bad;
    opc = ins[6:0];
    f3  = ins[14:12];
    f7  = ins[31:25];
    rd  = ins[11:7];
    a   = model_regs[ins[19:15]];
    b   = model_regs[ins[24:20]];
    imm = {{20{ins[31]}}, ins[31:20]};
    bad = 1'b0;
    val = '0;
    case (opc)
      opc_op: begin
        if (f7 == 7'h00) val = alu_ref(f3, 1'b0, a, b);
        else if (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)) val = alu_ref(f3, 1'b1, a, b);
        else bad = 1'b1;
      end
      opc_op_imm: begin
        // Shift immediates keep a funct7 in the upper bits
        if (f3 == 3'b001 && f7 != 7'h00) bad = 1'b1;
        else if (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20) bad = 1'b1;
        else val = alu_ref(f3, f3 == 3'b101 && f7 == 7'h20, a, imm);
      end
      opc_lui:   val = {ins[31:12], 12'b0};
      opc_auipc: val = pc + {ins[31:12], 12'b0};
      default:   bad = 1'b1;
    endcase
    if (!bad && rd != 5'd0) model_regs[rd] = val;
    exp_q.push_back({bad, rd, val});
    sent++;
  endtask

  task automatic check_result();
    logic [xlen+reg_addr_w:0] exp;
    logic                     exp_ill;
    if (exp_q.size() == 0) begin
      fail_run("A result arrived with no instruction outstanding");
    end else begin
      exp     = exp_q.pop_front();
      exp_ill = exp[xlen+reg_addr_w];
      received++;
      assert (result_illegal_o === exp_ill) else
        fail_run($sformatf("[FAIL] result_illegal_o expected %h actual %h",
                           exp_ill, result_illegal_o));
      assert (result_rd_o === exp[xlen+reg_addr_w-1:xlen]) else
        fail_run($sformatf("[FAIL] result_rd_o expected %h actual %h",
                           exp[xlen+reg_addr_w-1:xlen], result_rd_o));
      // Data of an illegal record carries no meaning
      if (!exp_ill) begin
        assert (result_data_o === exp[xlen-1:0]) else
          fail_run($sformatf("[FAIL] result_data_o expected %h actual %h",
                             exp[xlen-1:0], result_data_o));
      end
    end
  endtask

  initial begin
    arst_n_i       = 1'b0;
    instr_valid_i  = 1'b0;
    instr_i        = '0;
    instr_pc_i     = '0;
    result_ready_i = 1'b0;
    for (int i = 0; i < reg_count; i++) begin
      model_regs[i] = '0;
    end
    repeat (8) @(posedge clk);
    assert (instr_ready_o === 1'b1 && result_valid_o === 1'b0) else
      fail_run("The core is not idle at the end of reset");
    arst_n_i <= 1'b1;
  end

  always @(posedge clk) begin
    if (arst_n_i) begin
      if (instr_valid_i && instr_ready_o) accept_instr(instr_i, instr_pc_i);
      if (result_valid_o && result_ready_i) check_result();
      // A held instruction stays put until it is taken
      if (!instr_valid_i || instr_ready_o) begin
        if (sent < num_instr && ($random(seed) & 3) != 0) begin
          instr_valid_i <= 1'b1;
          instr_i       <= gen_instr();
          instr_pc_i    <= $random(seed) & 32'hffff_fffc;
        end else begin
          instr_valid_i <= 1'b0;
        end
      end
      result_ready_i <= ($random(seed) & 3) != 0;
    end
  end

  initial begin
    while (sent < num_instr || exp_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    if (received == num_instr && !result_valid_o && dut.u_checker.err_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("Run ended with %0d of %0d results or with handshake assertion errors",
               received, num_instr);
      $display("RESULT: FAIL");
      $fatal(1, "Run ended in error");
    end
  end

  initial begin
    #(num_instr * 20 * clk_period);
    $display("Timeout: the core stopped returning results before all instructions finished");
    $display("RESULT: FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule
